/* sources.f */
src/adder_geom_pkg.sv
src/check_types_pkg.sv
src/bk_group_adder.sv
src/ripple_group_adder.sv
src/bk_select_adder.sv
src/ripple_select_adder.sv
src/adder_check.sv
test/tb_adder_check.sv

/* src/adder_check.sv */
`timescale 1ns/1ps

module adder_check
    import adder_geom_pkg::*;
    import check_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  operands_t operands,
    output sum_t      result,
    output check_t    check
);

    sum_t   bk_sum;
    sum_t   rc_sum;
    check_t mismatch;

    bk_select_adder bk_adder_i (
        .operands (operands),
        .result   (bk_sum)
    );

    ripple_select_adder rc_adder_i (
        .operands (operands),
        .result   (rc_sum)
    );

    // Any bit set here marks a disagreement between the two adders.
    assign mismatch.check     = bk_sum.sum ^ rc_sum.sum;
    assign mismatch.checkcout = bk_sum.cout ^ rc_sum.cout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            check  <= '0;
        end else begin
            result <= bk_sum;     // the Brent-Kung adder is the reported result.
            check  <= mismatch;
        end
    end

    // both carry-select adders produce the same sum word.
    a_sum_agree: assert property (
        @(posedge clk) disable iff (!rst_n)
        check.check == {data_width{1'b0}}
    ) else $error("adder sums disagree, check = %h", check.check);

    a_cout_agree: assert property (
        @(posedge clk) disable iff (!rst_n)
        !check.checkcout
    ) else $error("adder carry-outs disagree");

    // The registered result is the true 33-bit sum of the operands one cycle earlier.
    a_sum_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |->
            {result.cout, result.sum} ==
            $past({1'b0, operands.a} + {1'b0, operands.b})
    ) else $error("result is not the operand sum of the previous cycle");

endmodule

/* src/adder_geom_pkg.sv */
package adder_geom_pkg;

    // Operand width of both adders.
    localparam int data_width = 32;

    // The word is split into eight carry-select groups that grow toward the top,
    // so each group's internal add settles about when its select carry arrives.
    localparam int num_groups = 8;
    localparam int last_group = num_groups - 1;

    // group k covers bits group_lsb[k] +: group_width[k].
    localparam int group_width [num_groups] = '{
        2,  // bits 1:0
        2,  // bits 3:2
        3,  // bits 6:4
        4,  // bits 10:7
        5,  // bits 15:11
        6,  // bits 21:16
        7,  // bits 28:22
        3   // bits 31:29
    };

    localparam int group_lsb [num_groups] = '{
        0,
        2,
        4,
        7,
        11,
        16,
        22,
        29
    };

    // Widest group in the partition.
    localparam int max_group_width = 7;

    // Group 0 has carry-in zero and no select, so only groups 1 to last_group
    // are built as selected pairs.
    localparam int first_select_group = 1;

endpackage

/* src/bk_group_adder.sv */
`timescale 1ns/1ps

module bk_group_adder
    import adder_geom_pkg::*;
#(
    parameter int width = max_group_width
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             sel,
    output logic [width-1:0] sum,
    output logic             cout
);

    localparam int levels = $clog2(width);
    localparam int stages = 2 * levels;
    localparam int last   = stages - 1;

    wire [width-1:0] gs [stages]; // group generate per prefix stage.
    wire [width-1:0] ps [stages]; // group propagate per prefix stage.

    logic [width-1:0] sum0;
    logic             cout0;
    logic [width-1:0] sum1;
    logic             cout1;
    logic [width:0]   ones;       // running AND of sum0 bits for the BEC.

    assign gs[0] = a & b;
    assign ps[0] = a ^ b;

    // Stages 1..levels form the up-sweep tree, the remaining stages fill in
    // the odd positions on the way back down.
    for (genvar s = 1; s < stages; s++) begin : g_stage
        localparam bit up   = (s <= levels);
        localparam int lvl  = up ? s - 1 : 2 * levels - 1 - s;
        localparam int span = 2 ** lvl;

        for (genvar i = 0; i < width; i++) begin : g_bit
            localparam bit up_node = up && ((i + 1) % (2 * span) == 0);
            localparam bit dn_node = !up && ((i + 1) % (2 * span) == span)
                                     && (i >= 2 * span);

            if (up_node || dn_node) begin : g_cell
                assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][i-span]);
                // a node whose span reaches bit 0 only needs the gray cell.
                if (up_node && (i + 1 != 2 * span)) begin : g_black
                    assign ps[s][i] = ps[s-1][i] & ps[s-1][i-span];
                end else begin : g_gray
                    assign ps[s][i] = ps[s-1][i];
                end
            end else begin : g_pass
                assign gs[s][i] = gs[s-1][i];
                assign ps[s][i] = ps[s-1][i];
            end
        end
    end

    // After the last stage gs[last][i] is the carry out of bit i with carry-in zero.
    assign sum0  = ps[0] ^ {gs[last][width-2:0], 1'b0};
    assign cout0 = gs[last][width-1];

    always_comb begin
        ones[0] = 1'b1;
        for (int i = 0; i < width; i++) begin
            ones[i+1] = ones[i] & sum0[i];
        end
    end

    // BEC output is the carry-in-zero result plus one.
    assign sum1  = sum0 ^ ones[width-1:0];
    assign cout1 = cout0 ^ ones[width];

    assign sum  = sel ? sum1 : sum0;
    assign cout = sel ? cout1 : cout0;

endmodule

/* src/bk_select_adder.sv */
`timescale 1ns/1ps

module bk_select_adder
    import adder_geom_pkg::*;
    import check_types_pkg::*;
(
    input  operands_t operands,
    output sum_t      result
);

    localparam int w0 = group_width[0];

    wire [data_width-1:0] sum_bits;
    wire [num_groups-1:0] carry;    // selected carry out of each group.

    logic [w0-1:0] g0;
    logic [w0-1:0] p0;
    logic [w0:0]   pre0;            // prefix generate of group 0.

    assign g0 = operands.a[group_lsb[0] +: w0] & operands.b[group_lsb[0] +: w0];
    assign p0 = operands.a[group_lsb[0] +: w0] ^ operands.b[group_lsb[0] +: w0];

    // Group 0 is only two bits wide, so its prefix is a single gray cell.
    always_comb begin
        pre0[0] = 1'b0;
        for (int i = 0; i < w0; i++) begin
            pre0[i+1] = g0[i] | (p0[i] & pre0[i]);
        end
    end

    assign sum_bits[group_lsb[0] +: w0] = p0 ^ pre0[w0-1:0];
    assign carry[0] = pre0[w0];

    for (genvar k = first_select_group; k < num_groups; k++) begin : g_group
        bk_group_adder #(
            .width(group_width[k])
        ) group_i (
            .a    (operands.a[group_lsb[k] +: group_width[k]]),
            .b    (operands.b[group_lsb[k] +: group_width[k]]),
            .sel  (carry[k-1]),
            .sum  (sum_bits[group_lsb[k] +: group_width[k]]),
            .cout (carry[k])
        );
    end

    assign result.sum  = sum_bits;
    assign result.cout = carry[last_group];

endmodule

/* src/check_types_pkg.sv */
package check_types_pkg;

    import adder_geom_pkg::*;

    // Operand pair presented to both adders.
    typedef struct packed {
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
    } operands_t;

    // Sum word and carry-out of one adder.
    typedef struct packed {
        logic [data_width-1:0] sum;
        logic                  cout;
    } sum_t;

    // Bitwise difference of the two adders; all zero when they agree.
    typedef struct packed {
        logic [data_width-1:0] check;
        logic                  checkcout;
    } check_t;

endpackage

/* src/ripple_group_adder.sv */
`timescale 1ns/1ps

module ripple_group_adder
    import adder_geom_pkg::*;
#(
    parameter int width = max_group_width
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             sel,
    output logic [width-1:0] sum,
    output logic             cout
);

    logic [width:0]   c_zero; // chain seeded with carry-in zero.
    logic [width:0]   c_one;  // chain seeded with carry-in one.
    logic [width-1:0] s_zero;
    logic [width-1:0] s_one;

    always_comb begin
        c_zero[0] = 1'b0;
        c_one[0]  = 1'b1;
        for (int i = 0; i < width; i++) begin
            s_zero[i]   = a[i] ^ b[i] ^ c_zero[i];
            c_zero[i+1] = (a[i] & b[i]) | ((a[i] ^ b[i]) & c_zero[i]);
            s_one[i]    = a[i] ^ b[i] ^ c_one[i];
            c_one[i+1]  = (a[i] & b[i]) | ((a[i] ^ b[i]) & c_one[i]);
        end
    end

    assign sum  = sel ? s_one : s_zero;
    assign cout = sel ? c_one[width] : c_zero[width];

endmodule

/* src/ripple_select_adder.sv */
`timescale 1ns/1ps

module ripple_select_adder
    import adder_geom_pkg::*;
    import check_types_pkg::*;
(
    input  operands_t operands,
    output sum_t      result
);

    localparam int w0 = group_width[0];

    wire [data_width-1:0] sum_bits;
    wire [num_groups-1:0] carry;    // selected carry out of each group.

    logic [w0-1:0] a0;
    logic [w0-1:0] b0;
    logic [w0-1:0] s0;
    logic [w0:0]   c0;              // ripple carries of group 0.

    assign a0 = operands.a[group_lsb[0] +: w0];
    assign b0 = operands.b[group_lsb[0] +: w0];

    always_comb begin
        c0[0] = 1'b0;
        for (int i = 0; i < w0; i++) begin
            s0[i]   = a0[i] ^ b0[i] ^ c0[i];
            c0[i+1] = (a0[i] & b0[i]) | ((a0[i] ^ b0[i]) & c0[i]);
        end
    end

    assign sum_bits[group_lsb[0] +: w0] = s0;
    assign carry[0] = c0[w0];

    // each group picks between its two chains on the carry of the group below.
    for (genvar k = first_select_group; k < num_groups; k++) begin : g_group
        ripple_group_adder #(
            .width(group_width[k])
        ) group_i (
            .a    (operands.a[group_lsb[k] +: group_width[k]]),
            .b    (operands.b[group_lsb[k] +: group_width[k]]),
            .sel  (carry[k-1]),
            .sum  (sum_bits[group_lsb[k] +: group_width[k]]),
            .cout (carry[k])
        );
    end

    assign result.sum  = sum_bits;
    assign result.cout = carry[last_group];

endmodule

/* test/tb_adder_check.sv */
`timescale 1ns/1ps

module tb_adder_check
    import adder_geom_pkg::*;
    import check_types_pkg::*;
();

    localparam int reset_cycles = 10;
    localparam int random_count = 256;
    // reset, about 50 directed cycles and 257 random cycles leave wide margin here.
    localparam int cycle_limit  = 1000;

    logic      clk;
    logic      rst_n;
    operands_t operands;
    sum_t      result;
    check_t    check;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state  = 16'd21;

    adder_check adder_check_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .operands (operands),
        .result   (result),
        .check    (check)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_word(output logic [data_width-1:0] word);
        for (int i = 0; i < data_width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word[i]    = lfsr_state[0]; // one step per bit taken.
        end
    endtask

    task automatic check_zero(input string phase);
        check_count++;
        if (result !== '0) begin
            error_count++;
            $display("** Error at %0t: result = %h, expected %h (%s)",
                     $time, result, {($bits(sum_t)){1'b0}}, phase);
        end
        if (check !== '0) begin
            error_count++;
            $display("** Error at %0t: check = %h, expected %h (%s)",
                     $time, check, {($bits(check_t)){1'b0}}, phase);
        end
    endtask

    task automatic check_outputs(input logic [data_width-1:0] a,
                                 input logic [data_width-1:0] b);
        logic [data_width:0] expected;
        expected = {1'b0, a} + {1'b0, b};
        check_count++;
        if (result.sum !== expected[data_width-1:0]) begin
            error_count++;
            $display("** Error at %0t: result.sum = %h, expected %h (a = %h, b = %h)",
                     $time, result.sum, expected[data_width-1:0], a, b);
        end
        if (result.cout !== expected[data_width]) begin
            error_count++;
            $display("** Error at %0t: result.cout = %b, expected %b (a = %h, b = %h)",
                     $time, result.cout, expected[data_width], a, b);
        end
        if (check.check !== '0) begin
            error_count++;
            $display("** Error at %0t: check.check = %h, expected %h (a = %h, b = %h)",
                     $time, check.check, {data_width{1'b0}}, a, b);
        end
        if (check.checkcout !== 1'b0) begin
            error_count++;
            $display("** Error at %0t: check.checkcout = %b, expected 0 (a = %h, b = %h)",
                     $time, check.checkcout, a, b);
        end
    endtask

    // The registered outputs are read on the falling edge after the capturing edge.
    task automatic apply_vector(input logic [data_width-1:0] a,
                                input logic [data_width-1:0] b);
        @(posedge clk);
        operands.a <= a;
        operands.b <= b;
        @(posedge clk);
        @(negedge clk);
        check_outputs(a, b);
    endtask

    task automatic test_reset();
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            check_zero("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_zero("after reset release");  // no operand edge seen out of reset yet.
    endtask

    task automatic test_small_sums();
        apply_vector(32'd0, 32'd0);
        apply_vector(32'd1, 32'd1);
        apply_vector(32'd3, 32'd5);
        apply_vector(32'd12345, 32'd54321);
        apply_vector(32'h1234_5678, 32'h0101_0101);
    endtask

    task automatic test_group_carries();
        logic [63:0] below;
        logic [63:0] through;
        for (int k = 0; k < num_groups; k++) begin
            below   = (64'd1 << group_lsb[k]) - 64'd1;
            through = (64'd1 << (group_lsb[k] + group_width[k])) - 64'd1;
            apply_vector(below[data_width-1:0], 32'd1);   // carry lands on the group's low bit.
            apply_vector(through[data_width-1:0], 32'd1); // carry runs through the whole group.
        end
    endtask

    task automatic test_overflow();
        apply_vector(32'hffff_ffff, 32'h0000_0001);
        apply_vector(32'hffff_ffff, 32'hffff_ffff);
        apply_vector(32'h8000_0000, 32'h8000_0000);
    endtask

    task automatic test_random(input int count);
        operands_t             pending [$];
        operands_t             vec;
        logic [data_width-1:0] word_a;
        logic [data_width-1:0] word_b;
        for (int i = 0; i < count; i++) begin
            draw_word(word_a);
            draw_word(word_b);
            @(posedge clk);
            operands.a <= word_a;
            operands.b <= word_b;
            pending.push_back({word_a, word_b});
            @(negedge clk);
            if (i > 0) begin
                vec = pending.pop_front(); // the edge just passed captured this pair.
                check_outputs(vec.a, vec.b);
            end
        end
        @(posedge clk);
        @(negedge clk);
        vec = pending.pop_front();
        check_outputs(vec.a, vec.b);
    endtask

    initial begin
        rst_n      = 1'b0;
        operands.a = 32'hdead_beef; // nonzero so a leaky reset would show.
        operands.b = 32'h0f0f_0f0f;
        test_reset();
        test_small_sums();
        test_group_carries();
        test_overflow();
        test_random(random_count);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
